// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = fetchFrontEndTb
FILELIST = sources.f
BUILD_DIR = obj_dir
LOG = sim.log

SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/branchPredictor.sv
// Branch target predictor
// Direct-mapped BTB with 2-bit saturating counters, one lookup per
// lane and one training port from the backend
`timescale 1ns/10ps

module branchPredictor #(
    parameter int fetchWidth = 2,
    parameter int btbEntries = 32
) (
    input logic clk,
    input logic rstN,
    input logic [fetchPkg::addrWidth-1:0] lookupPc [fetchWidth],
    output fetchPkg::brPred pred [fetchWidth],
    input fetchPkg::brUpdate train
);

    localparam int idxBits = $clog2(btbEntries);
    localparam int tagBits = fetchPkg::addrWidth - fetchPkg::insnOffsetBits - idxBits;

    logic [tagBits-1:0] tagTable [btbEntries];
    logic [fetchPkg::addrWidth-1:0] targetTable [btbEntries];
    logic [1:0] ctrTable [btbEntries];
    logic [btbEntries-1:0] entryValid;

    logic [idxBits-1:0] lookupIdx [fetchWidth];
    logic [tagBits-1:0] lookupTag [fetchWidth];
    logic [idxBits-1:0] trainIdx;
    logic [tagBits-1:0] trainTag;
    logic trainHit;
    logic trainWrite;
    logic [1:0] trainCtr;

    // Per-lane lookup
    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            lookupIdx[i] = lookupPc[i][fetchPkg::insnOffsetBits +: idxBits];
            lookupTag[i] = lookupPc[i][fetchPkg::addrWidth-1 -: tagBits];
            pred[i].predTarget = targetTable[lookupIdx[i]];
            pred[i].counter = ctrTable[lookupIdx[i]];
            // Taken only on a tag match with a counter of 2 or 3
            pred[i].predTaken = entryValid[lookupIdx[i]]
                && (tagTable[lookupIdx[i]] == lookupTag[i])
                && ctrTable[lookupIdx[i]][1];
        end
    end

    // Training
    always_comb begin
        trainIdx = train.pc[fetchPkg::insnOffsetBits +: idxBits];
        trainTag = train.pc[fetchPkg::addrWidth-1 -: tagBits];
        trainHit = entryValid[trainIdx] && (tagTable[trainIdx] == trainTag);
        if (!trainHit) begin
            trainCtr = 2'd2;   // fresh entry starts weakly taken
        end else if (train.taken) begin
            trainCtr = (ctrTable[trainIdx] == 2'd3) ? 2'd3 : ctrTable[trainIdx] + 2'd1;
        end else begin
            trainCtr = (ctrTable[trainIdx] == 2'd0) ? 2'd0 : ctrTable[trainIdx] - 2'd1;
        end
        // Not-taken misses allocate nothing
        trainWrite = train.valid && (trainHit || train.taken);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            entryValid <= '0;
        end else if (trainWrite) begin
            entryValid[trainIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (trainWrite) begin
            tagTable[trainIdx] <= trainTag;
            ctrTable[trainIdx] <= trainCtr;
            if (train.taken) begin
                targetTable[trainIdx] <= train.target;
            end
        end
    end

endmodule

// File: design/fetchFrontEnd.sv
// Instruction fetch front end
// Next-PC stage, fetch stage, instruction cache and BTB
`timescale 1ns/10ps

module fetchFrontEnd #(
    parameter int fetchWidth = 2,
    parameter int cacheLines = 16,
    parameter int btbEntries = 32,
    parameter logic [fetchPkg::addrWidth-1:0] resetPc = '0
) (
    input logic clk,
    input logic rstN,
    input fetchPkg::redirectReq redirect,
    input logic decodeStall,
    input fetchPkg::brUpdate brTrain,
    output fetchPkg::memReq memOut,
    input logic memRespValid,
    input logic [fetchPkg::insnWidth-1:0] memRespData [fetchWidth],
    output fetchPkg::fetchLane lanes [fetchWidth]
);

    logic [fetchPkg::addrWidth-1:0] fetchPc;
    logic [fetchPkg::laneIdxWidth-1:0] lane0Offset;
    logic stall;
    logic steerValid;
    logic [fetchPkg::addrWidth-1:0] steerPc;
    logic [fetchPkg::addrWidth-1:0] lookupAddr;
    logic lookupEn;
    logic cacheHit;
    logic [fetchPkg::insnWidth-1:0] cacheData [fetchWidth];
    logic [fetchPkg::addrWidth-1:0] lanePc [fetchWidth];
    fetchPkg::brPred pred [fetchWidth];

    nextPcStage #(.fetchWidth(fetchWidth), .resetPc(resetPc)) nextPc (
        .clk(clk), .rstN(rstN), .redirect(redirect), .stall(stall),
        .steerValid(steerValid), .steerPc(steerPc),
        .fetchPc(fetchPc), .lane0Offset(lane0Offset)
    );

    fetchStage #(.fetchWidth(fetchWidth)) fetch (
        .clk(clk), .rstN(rstN), .fetchPc(fetchPc), .lane0Offset(lane0Offset),
        .redirect(redirect), .decodeStall(decodeStall),
        .cacheHit(cacheHit), .cacheData(cacheData),
        .lookupAddr(lookupAddr), .lookupEn(lookupEn), .lanePc(lanePc), .pred(pred),
        .stall(stall), .steerValid(steerValid), .steerPc(steerPc), .lanes(lanes)
    );

    instCache #(.fetchWidth(fetchWidth), .cacheLines(cacheLines)) icache (
        .clk(clk), .rstN(rstN), .lookupAddr(lookupAddr), .lookupEn(lookupEn),
        .hit(cacheHit), .lineData(cacheData), .memOut(memOut),
        .memRespValid(memRespValid), .memRespData(memRespData)
    );

    branchPredictor #(.fetchWidth(fetchWidth), .btbEntries(btbEntries)) btb (
        .clk(clk), .rstN(rstN), .lookupPc(lanePc), .pred(pred), .train(brTrain)
    );

endmodule

// File: design/fetchPkg.sv
// Fetch front end shared definitions
// Common widths, per-lane structs and PC helper constants
package fetchPkg;

    localparam int addrWidth = 32;
    localparam int insnWidth = 32;
    localparam int insnBytes = 4;
    // Upper bound for the fetch width of any instance
    localparam int maxFetchWidth = 4;

    // PC helpers
    localparam int insnOffsetBits = $clog2(insnBytes);
    localparam int laneIdxWidth = $clog2(maxFetchWidth);

    typedef logic [laneIdxWidth-1:0] laneIdx;

    // Prediction attached to one lane
    typedef struct packed {
        logic predTaken;
        logic [addrWidth-1:0] predTarget;
        logic [1:0] counter;
    } brPred;

    // One instruction slot handed to decode
    typedef struct packed {
        logic valid;
        logic [addrWidth-1:0] pc;
        logic [insnWidth-1:0] insn;
        brPred pred;
    } fetchLane;

    // Branch resolution from the backend
    typedef struct packed {
        logic valid;
        logic [addrWidth-1:0] pc;
        logic taken;
        logic [addrWidth-1:0] target;
    } brUpdate;

    typedef struct packed {
        logic valid;
        logic [addrWidth-1:0] pc;
    } redirectReq;

    // Refill request, line aligned byte address
    typedef struct packed {
        logic valid;
        logic [addrWidth-1:0] lineAddr;
    } memReq;

endpackage

// File: design/fetchStage.sv
// Fetch stage
// Holds the group in flight, looks it up in the cache, applies the
// branch predictions and hands the lanes to decode
`timescale 1ns/10ps

module fetchStage #(
    parameter int fetchWidth = 2
) (
    input logic clk,
    input logic rstN,
    input logic [fetchPkg::addrWidth-1:0] fetchPc,
    input logic [fetchPkg::laneIdxWidth-1:0] lane0Offset,
    input fetchPkg::redirectReq redirect,
    input logic decodeStall,
    input logic cacheHit,
    input logic [fetchPkg::insnWidth-1:0] cacheData [fetchWidth],
    output logic [fetchPkg::addrWidth-1:0] lookupAddr,
    output logic lookupEn,
    output logic [fetchPkg::addrWidth-1:0] lanePc [fetchWidth],
    input fetchPkg::brPred pred [fetchWidth],
    output logic stall,
    output logic steerValid,
    output logic [fetchPkg::addrWidth-1:0] steerPc,
    output fetchPkg::fetchLane lanes [fetchWidth]
);

    localparam logic [fetchPkg::addrWidth-1:0] groupBytes = fetchWidth * fetchPkg::insnBytes;

    // Fetch register
    logic [fetchPkg::addrWidth-1:0] groupPc;
    logic [fetchWidth-1:0] laneValid;

    logic regStall;
    logic beginStall;
    logic loadGroup;
    logic takenSeen;
    logic [fetchWidth-1:0] isFlushed;

    // Predictions held from the first stall cycle
    fetchPkg::brPred regPred [fetchWidth];
    fetchPkg::brPred curPred [fetchWidth];

    always_comb begin
        lookupAddr = groupPc;
        lookupEn = |laneValid;
        // Miss or back-pressure holds the group
        stall = (lookupEn && !cacheHit) || decodeStall;
        beginStall = stall && !regStall;
        // A redirect replaces the group even while stalled
        loadGroup = redirect.valid || !stall;
        steerValid = |laneValid;
        for (int i = 0; i < fetchWidth; i++) begin
            lanePc[i] = groupPc + i * fetchPkg::insnBytes;
            curPred[i] = regStall ? regPred[i] : pred[i];
        end
    end

    // Lanes after the first predicted-taken lane are dropped
    always_comb begin
        takenSeen = 1'b0;
        steerPc = groupPc + groupBytes;
        for (int i = 0; i < fetchWidth; i++) begin
            isFlushed[i] = takenSeen && laneValid[i];
            if (!takenSeen && laneValid[i] && curPred[i].predTaken) begin
                takenSeen = 1'b1;
                steerPc = curPred[i].predTarget;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            laneValid <= '0;
            regStall <= 1'b0;
        end else begin
            // New group after a redirect starts a fresh stall episode
            regStall <= stall && !redirect.valid;
            if (loadGroup) begin
                for (int i = 0; i < fetchWidth; i++) begin
                    laneValid[i] <= fetchPkg::laneIdx'(i) >= lane0Offset;
                end
            end else begin
                laneValid <= laneValid & ~isFlushed;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadGroup) begin
            groupPc <= fetchPc;
        end
        if (beginStall) begin
            regPred <= pred;
        end
    end

    // Output group to decode
    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            lanes[i].valid = laneValid[i] && !stall && !redirect.valid && !isFlushed[i];
            lanes[i].pc = lanePc[i];
            lanes[i].insn = cacheData[i];
            lanes[i].pred = curPred[i];
        end
    end

endmodule

// File: design/instCache.sv
// Instruction cache
// Direct mapped, one fetch group per line, single outstanding refill
// through the external memory port
`timescale 1ns/10ps

module instCache #(
    parameter int fetchWidth = 2,
    parameter int cacheLines = 16
) (
    input logic clk,
    input logic rstN,
    input logic [fetchPkg::addrWidth-1:0] lookupAddr,
    input logic lookupEn,
    output logic hit,
    output logic [fetchPkg::insnWidth-1:0] lineData [fetchWidth],
    output fetchPkg::memReq memOut,
    input logic memRespValid,
    input logic [fetchPkg::insnWidth-1:0] memRespData [fetchWidth]
);

    localparam int offsetBits = $clog2(fetchWidth * fetchPkg::insnBytes);
    localparam int indexBits = $clog2(cacheLines);
    localparam int tagBits = fetchPkg::addrWidth - offsetBits - indexBits;

    logic [tagBits-1:0] tagArray [cacheLines];
    logic [fetchPkg::insnWidth-1:0] dataArray [cacheLines][fetchWidth];
    logic [cacheLines-1:0] lineValid;

    logic refillBusy;
    logic [fetchPkg::addrWidth-1:0] refillAddr;
    logic [indexBits-1:0] lookupIdx;
    logic [tagBits-1:0] lookupTag;
    logic [indexBits-1:0] refillIdx;
    logic startRefill;

    always_comb begin
        lookupIdx = lookupAddr[offsetBits +: indexBits];
        lookupTag = lookupAddr[fetchPkg::addrWidth-1 -: tagBits];
        refillIdx = refillAddr[offsetBits +: indexBits];
        hit = lineValid[lookupIdx] && (tagArray[lookupIdx] == lookupTag);
        for (int i = 0; i < fetchWidth; i++) begin
            lineData[i] = dataArray[lookupIdx][i];
        end
        // New miss waits until the current refill is done
        startRefill = lookupEn && !hit && !refillBusy;
        memOut.valid = refillBusy;
        memOut.lineAddr = refillAddr;
    end

    // Refill control, a redirect does not cancel an open refill
    always_ff @(posedge clk) begin
        if (!rstN) begin
            lineValid <= '0;
            refillBusy <= 1'b0;
        end else if (refillBusy) begin
            if (memRespValid) begin
                lineValid[refillIdx] <= 1'b1;
                refillBusy <= 1'b0;
            end
        end else if (startRefill) begin
            refillBusy <= 1'b1;
        end
    end

    // Tags, data and the request address
    always_ff @(posedge clk) begin
        if (startRefill) begin
            refillAddr <= lookupAddr;
        end
        if (refillBusy && memRespValid) begin
            tagArray[refillIdx] <= refillAddr[fetchPkg::addrWidth-1 -: tagBits];
            for (int i = 0; i < fetchWidth; i++) begin
                dataArray[refillIdx][i] <= memRespData[i];
            end
        end
    end

endmodule

// File: design/nextPcStage.sv
// Next-PC stage
// Picks the address of the next fetch group and splits it into
// the aligned group address and the first valid lane
`timescale 1ns/10ps

module nextPcStage #(
    parameter int fetchWidth = 2,
    parameter logic [fetchPkg::addrWidth-1:0] resetPc = '0
) (
    input logic clk,
    input logic rstN,
    input fetchPkg::redirectReq redirect,
    input logic stall,
    input logic steerValid,
    input logic [fetchPkg::addrWidth-1:0] steerPc,
    output logic [fetchPkg::addrWidth-1:0] fetchPc,
    output logic [fetchPkg::laneIdxWidth-1:0] lane0Offset
);

    localparam logic [fetchPkg::addrWidth-1:0] groupBytes = fetchWidth * fetchPkg::insnBytes;

    // Fetch address register, successor of the last group sent on
    logic [fetchPkg::addrWidth-1:0] pcReg;
    logic [fetchPkg::addrWidth-1:0] nextPc;
    logic [fetchPkg::addrWidth-1:0] groupOffset;

    always_comb begin
        // Redirect wins, then the steering target of the group in fetch
        if (redirect.valid) begin
            nextPc = redirect.pc;
        end else if (steerValid) begin
            nextPc = steerPc;
        end else begin
            nextPc = pcReg;
        end
        groupOffset = nextPc & (groupBytes - 1'b1);
        fetchPc = nextPc & ~(groupBytes - 1'b1);
        // Misaligned entry point skips the leading lanes
        lane0Offset = fetchPkg::laneIdx'(groupOffset >> fetchPkg::insnOffsetBits);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcReg <= resetPc;
        end else if (redirect.valid || !stall) begin
            pcReg <= fetchPc + groupBytes;
        end
    end

endmodule

// File: sources.f
design/fetchPkg.sv
design/nextPcStage.sv
design/branchPredictor.sv
design/instCache.sv
design/fetchStage.sv
design/fetchFrontEnd.sv
tb/fetchClockGen.sv
tb/fetchFrontEndTb.sv

// File: tb/fetchClockGen.sv
// Fetch testbench clock and reset
// Free-running clock and a synchronous active-low reset pulse
`timescale 1ns/10ps

module fetchClockGen #(
    parameter int periodNs = 20,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Reset released on a rising edge after the hold time
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

// File: tb/fetchFrontEndTb.sv
// Fetch front end testbench
// Serves the refill port, runs the commands of the stimulus file and
// compares the delivered groups with the expected PCs and lane masks
`timescale 1ns/10ps

module fetchFrontEndTb;

    localparam int fetchWidth = 2;
    localparam int maxGroups = 3;
    localparam int cyclesPerTest = 200;
    localparam logic [31:0] insnKey = 32'h5a5a0000;

    logic clk;
    logic rstN;
    fetchPkg::redirectReq redirect;
    logic decodeStall;
    fetchPkg::brUpdate brTrain;
    fetchPkg::memReq memOut;
    logic memRespValid;
    logic [31:0] memRespData [fetchWidth];
    fetchPkg::fetchLane lanes [fetchWidth];

    // Parsed stimulus with expected groups flattened by maxGroups
    string nameQ[$];
    string cmdQ[$];
    logic [31:0] opA[$];
    logic [31:0] opB[$];
    logic [31:0] opC[$];
    int nExp[$];
    logic [31:0] expPc[$];
    logic [3:0] expMask[$];

    // Delivered groups and refill requests seen by the monitors
    logic [31:0] gotPc[$];
    logic [3:0] gotMask[$];
    logic [31:0] reqAddr[$];

    // Expected BTB state per trained branch PC
    logic [1:0] btbCtr [logic [31:0]];
    logic [31:0] btbTarget [logic [31:0]];

    string curName = "reset";
    int errorCount = 0;
    int numTests = 0;
    int passCount = 0;
    logic prevMemValid = 1'b0;
    logic [31:0] servAddr;
    int servLat;

    fetchClockGen #(.periodNs(20), .resetCycles(5)) clkGen (.clk(clk), .rstN(rstN));

    fetchFrontEnd #(.fetchWidth(fetchWidth)) uut (
        .clk(clk), .rstN(rstN), .redirect(redirect), .decodeStall(decodeStall),
        .brTrain(brTrain), .memOut(memOut), .memRespValid(memRespValid),
        .memRespData(memRespData), .lanes(lanes)
    );

    // Memory model returns each word as its address XOR the key
    always begin
        @(negedge clk);
        if (rstN && memOut.valid) begin
            servLat = 1 + ($urandom % 6);
            servAddr = memOut.lineAddr;
            repeat (servLat - 1) @(negedge clk);
            @(posedge clk);
            memRespValid <= 1'b1;
            for (int i = 0; i < fetchWidth; i++) begin
                memRespData[i] <= (servAddr + 32'(i * 4)) ^ insnKey;
            end
            @(posedge clk);
            memRespValid <= 1'b0;
        end
    end

    // Output monitor samples away from the driving edge
    always @(negedge clk) begin
        logic [3:0] mask;
        logic [31:0] lanePcExp;
        mask = '0;
        for (int i = 0; i < fetchWidth; i++) begin
            // Lane PCs follow the group PC one word apart
            lanePcExp = lanes[0].pc + 32'(i * 4);
            if (lanes[i].valid) begin
                mask[i] = 1'b1;
                mask[i + 2] = lanes[i].pred.predTaken;
                checkLane(lanes[i], lanePcExp);
            end
        end
        if (rstN && mask != 4'd0) begin
            gotPc.push_back(lanes[0].pc);
            gotMask.push_back(mask);
        end
        // New refill request on a rising memOut.valid
        if (rstN && memOut.valid && !prevMemValid) begin
            reqAddr.push_back(memOut.lineAddr);
        end
        prevMemValid <= memOut.valid;
    end

    // Watchdog sized from the number of tests
    initial begin
        wait (numTests > 0);
        repeat (numTests * cyclesPerTest) @(posedge clk);
        $display("Run timed out after %0d cycles", numTests * cyclesPerTest);
        $display("TESTS FAILED");
        $finish;
    end

    // One valid lane against the memory rule and the trained BTB entries
    task automatic checkLane(input fetchPkg::fetchLane lane, input logic [31:0] pcExp);
        if (lane.pc !== pcExp) begin
            $display("FAILED %s: lane pc expected %h actual %h", curName, pcExp, lane.pc);
            errorCount++;
        end
        if (lane.insn !== (pcExp ^ insnKey)) begin
            $display("FAILED %s: insn at %h expected %h actual %h", curName,
                     pcExp, pcExp ^ insnKey, lane.insn);
            errorCount++;
        end
        if (btbCtr.exists(pcExp)) begin
            if (lane.pred.counter !== btbCtr[pcExp]) begin
                $display("FAILED %s: counter at %h expected %h actual %h", curName,
                         pcExp, btbCtr[pcExp], lane.pred.counter);
                errorCount++;
            end
            if (btbCtr[pcExp][1] && lane.pred.predTarget !== btbTarget[pcExp]) begin
                $display("FAILED %s: target at %h expected %h actual %h", curName,
                         pcExp, btbTarget[pcExp], lane.pred.predTarget);
                errorCount++;
            end
        end
    endtask

    // Taken misses allocate at 2, hits count up or down and saturate
    task automatic trainBtbModel(input logic [31:0] pc, input logic [31:0] target,
                                 input logic taken);
        if (btbCtr.exists(pc)) begin
            if (taken) begin
                btbTarget[pc] = target;
                if (btbCtr[pc] != 2'd3) begin
                    btbCtr[pc] = btbCtr[pc] + 2'd1;
                end
            end else if (btbCtr[pc] != 2'd0) begin
                btbCtr[pc] = btbCtr[pc] - 2'd1;
            end
        end else if (taken) begin
            btbCtr[pc] = 2'd2;
            btbTarget[pc] = target;
        end
    endtask

    task automatic loadStimulus();
        int fd;
        int cnt;
        int n;
        string line;
        string nm;
        string cm;
        logic [31:0] a, b, c, p0, p1, p2;
        logic [3:0] m0, m1, m2;
        fd = $fopen("tb/fetchStimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file tb/fetchStimulus.txt");
            errorCount++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            // Skip blank and comment lines
            if (cnt == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%s %s %h %h %h %d %h %h %h %h %h %h",
                          nm, cm, a, b, c, n, p0, m0, p1, m1, p2, m2);
            if (cnt != 12) begin
                $display("Malformed stimulus line: %s", line);
                errorCount++;
                continue;
            end
            nameQ.push_back(nm);
            cmdQ.push_back(cm);
            opA.push_back(a);
            opB.push_back(b);
            opC.push_back(c);
            nExp.push_back(n);
            expPc.push_back(p0);
            expPc.push_back(p1);
            expPc.push_back(p2);
            expMask.push_back(m0);
            expMask.push_back(m1);
            expMask.push_back(m2);
        end
        $fclose(fd);
    endtask

    task automatic runTest(input int t);
        int errBefore;
        logic [31:0] lineExp;
        errBefore = errorCount;
        curName = nameQ[t];
        lineExp = opA[t] & ~(32'(fetchWidth * 4) - 32'd1);
        if (cmdQ[t] == "redirect" || cmdQ[t] == "stall") begin
            @(posedge clk);
            gotPc.delete();
            gotMask.delete();
            reqAddr.delete();
            redirect.valid <= 1'b1;
            redirect.pc <= opA[t];
            decodeStall <= (cmdQ[t] == "stall");
            @(posedge clk);
            redirect.valid <= 1'b0;
            if (cmdQ[t] == "stall") begin
                // Window starts once the target line is written
                while (!(memRespValid && servAddr == lineExp)) @(posedge clk);
                // Nothing may reach decode in the back-pressure window
                for (int k = 0; k < int'(opB[t]); k++) begin
                    @(negedge clk);
                    if (lanes[0].valid || lanes[1].valid) begin
                        $display("Test %s saw a valid lane while decodeStall was high", curName);
                        errorCount++;
                    end
                    @(posedge clk);
                end
                decodeStall <= 1'b0;
            end
        end else if (cmdQ[t] == "train") begin
            @(posedge clk);
            brTrain.valid <= 1'b1;
            brTrain.pc <= opA[t];
            brTrain.target <= opB[t];
            brTrain.taken <= opC[t][0];
            @(posedge clk);
            brTrain.valid <= 1'b0;
            trainBtbModel(opA[t], opB[t], opC[t][0]);
            repeat (2) @(posedge clk);
        end else if (cmdQ[t] != "run") begin
            $display("Test %s has an unknown command %s", curName, cmdQ[t]);
            errorCount++;
        end
        while (gotPc.size() < nExp[t]) @(posedge clk);
        for (int k = 0; k < nExp[t]; k++) begin
            if (gotPc[k] !== expPc[t * maxGroups + k]) begin
                $display("FAILED %s: group %0d pc expected %h actual %h", curName, k,
                         expPc[t * maxGroups + k], gotPc[k]);
                errorCount++;
            end
            if (gotMask[k] !== expMask[t * maxGroups + k]) begin
                $display("FAILED %s: group %0d mask expected %h actual %h", curName, k,
                         expMask[t * maxGroups + k], gotMask[k]);
                errorCount++;
            end
        end
        // Reused lines must come from the cache
        if (cmdQ[t] == "redirect" && opB[t] == 32'd1) begin
            foreach (reqAddr[r]) begin
                for (int k = 0; k < nExp[t]; k++) begin
                    if (reqAddr[r] == expPc[t * maxGroups + k]) begin
                        $display("Test %s requested a refill for cached line %h",
                                 curName, reqAddr[r]);
                        errorCount++;
                    end
                end
            end
        end
        if (errorCount == errBefore) begin
            passCount++;
            $display("test %s: ok", curName);
        end else begin
            $display("test %s: %0d error(s)", curName, errorCount - errBefore);
        end
    endtask

    initial begin
        void'($urandom(32'ha2a127f2));
        redirect = '0;
        decodeStall = 1'b0;
        brTrain = '0;
        memRespValid = 1'b0;
        for (int i = 0; i < fetchWidth; i++) begin
            memRespData[i] = '0;
        end
        loadStimulus();
        numTests = nameQ.size();
        wait (rstN === 1'b1);
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", numTests, passCount,
                 numTests - passCount, errorCount);
        if (errorCount == 0 && numTests > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb/fetchStimulus.txt
# name cmd opA opB opC groups pc0 mask0 pc1 mask1 pc2 mask2 (hex except groups)
# mask bits 1:0 lane valid, bits 3:2 lane predicted taken
# redirect: opA target, opB 1 when the groups must not refill
# stall: opA target, opB cycles that decodeStall is held
# train: opA branch pc, opB target, opC taken
seqFetch run 0 0 0 3 00000000 3 00000008 3 00000010 3
misaligned redirect 00000244 0 0 3 00000240 2 00000248 3 00000250 3
backPressure stall 000004b0 6 0 3 000004b0 3 000004b8 3 000004c0 3
cacheReuse redirect 00000000 1 0 2 00000000 3 00000008 3 00000000 0
trainTaken train 00000600 00000720 1 0 00000000 0 00000000 0 00000000 0
predictTaken redirect 00000600 0 0 3 00000600 5 00000720 3 00000728 3
untrainOnce train 00000600 00000720 0 0 00000000 0 00000000 0 00000000 0
untrainTwice train 00000600 00000720 0 0 00000000 0 00000000 0 00000000 0
seqAfterUntrain redirect 00000600 0 0 3 00000600 3 00000608 3 00000610 3
